// File: rtl/bubble_loader_pkg.sv
`default_nettype none

package bubble_loader_pkg;

    localparam logic [7:0] FLASH_READ_CMD = 8'h03;  // plain serial read

    localparam int PAGE_COUNT    = 2053;   // slots 0x000 to 0x804
    localparam int BOOT_SLOT     = 'h805;  // bootloader follows the last page slot
    localparam int BOOT_BITS     = 2656;
    localparam int MAP_BITS      = 1168;   // bad-loop map sits right after the bootloader
    localparam int PREAMBLE_BITS = 6;      // good loops forced to one
    localparam int PAGE_BITS     = 1030;

    localparam int BOOT_BUF_BASE = 4106;
    localparam int PAGE_BUF_BASE = 14336;

    localparam int MAP_DEPTH   = 4096;
    localparam int POS_W       = 12;       // position and page number
    localparam int BUF_AW      = 15;
    localparam int FLASH_AW    = 24;       // 00 + image + slot + 7-bit byte offset
    localparam int PAGE_STRIDE = 3;

endpackage

`default_nettype wire

// File: rtl/flash_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface flash_rd_if import bubble_loader_pkg::*; ();

    logic                start;       // one-cycle pulse, accepted while busy is low
    logic [FLASH_AW-1:0] addr;
    logic                bit_req;     // one SCK period per pulse
    logic                release_cs;  // raises chip select
    logic                busy;        // high while the header is shifted out
    logic                bit_valid;   // 4 cycles after bit_req
    logic                bit_data;

    modport seq (
        output start, addr, bit_req, release_cs,
        input  busy, bit_valid, bit_data
    );

    modport reader (
        input  start, addr, bit_req, release_cs,
        output busy, bit_valid, bit_data
    );

endinterface

`default_nettype wire

// File: rtl/spi_flash_reader.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash_reader import bubble_loader_pkg::*;
(
    input  wire        MCLK,
    input  wire        rst_n,
    flash_rd_if.reader flash,
    output logic       cs_n,
    output logic       sck,
    output logic       mosi,
    input  wire        miso
);

    logic [31:0] sr;       // command byte then 24-bit address
    logic [6:0]  hdr_cnt;  // 2 setup cycles, then 64 half periods
    logic        hdr_act;
    logic [1:0]  bit_ph;
    logic        bit_act;

    assign mosi = sr[31];

    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cs_n            <= 1'b1;
            sck             <= 1'b1;  // SCK idles high
            sr              <= '0;
            hdr_cnt         <= '0;
            hdr_act         <= 1'b0;
            bit_ph          <= '0;
            bit_act         <= 1'b0;
            flash.busy      <= 1'b0;
            flash.bit_valid <= 1'b0;
            flash.bit_data  <= 1'b0;
        end
        else
        begin
            flash.bit_valid <= 1'b0;
            if (flash.release_cs)
            begin
                cs_n <= 1'b1;
                sck  <= 1'b1;
            end
            else if (flash.start && !flash.busy)
            begin
                cs_n       <= 1'b0;
                flash.busy <= 1'b1;
                sr         <= {FLASH_READ_CMD, flash.addr};
                hdr_cnt    <= '0;
                hdr_act    <= 1'b1;
            end
            else if (hdr_act)
            begin
                hdr_cnt <= hdr_cnt + 7'd1;
                if (hdr_cnt == 7'd65)
                begin
                    hdr_act    <= 1'b0;
                    flash.busy <= 1'b0;
                end
                else if (hdr_cnt != 7'd0)
                begin
                    sck <= ~hdr_cnt[0];  // odd count is the low phase
                    // the first bit is already on mosi from the load
                    if (hdr_cnt[0] && hdr_cnt != 7'd1)
                        sr <= {sr[30:0], 1'b0};
                end
            end
            else if (bit_act)
            begin
                bit_ph <= bit_ph + 2'd1;
                if (bit_ph == 2'd0)
                begin
                    sck            <= 1'b1;
                    flash.bit_data <= miso;  // sampled on the rising edge
                end
                else if (bit_ph == 2'd2)
                begin
                    bit_act         <= 1'b0;
                    flash.bit_valid <= 1'b1;
                end
            end
            else if (flash.bit_req)
            begin
                sck     <= 1'b0;  // flash shifts the next bit out
                bit_act <= 1'b1;
                bit_ph  <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/bad_loop_map.sv
`timescale 1ns/1ps
`default_nettype none

module bad_loop_map import bubble_loader_pkg::*;
(
    input  wire  MCLK,
    input  wire  rst_n,
    input  wire  wr,
    input  wire  wr_data,
    input  wire  rd,
    output logic rd_data
);

    logic             mem [MAP_DEPTH];
    logic [POS_W-1:0] wr_cnt;
    logic [POS_W-1:0] rd_cnt;
    logic [POS_W-1:0] good_cnt;  // good loops seen in the current page
    logic             rd_q;

    always_ff @(posedge MCLK)
    begin
        if (wr)
            mem[{wr_cnt[POS_W-1:4], ~wr_cnt[3:0]}] <= wr_data;  // low nibble inverted
        if (rd)
            rd_data <= mem[rd_cnt];
    end

    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_cnt   <= '0;
            rd_cnt   <= '0;
            good_cnt <= '0;
            rd_q     <= 1'b0;
        end
        else
        begin
            rd_q <= rd;
            if (wr)
            begin
                // a map write belongs to a boot load, so the read side restarts
                wr_cnt   <= (wr_cnt == POS_W'(MAP_BITS - 1)) ? '0 : wr_cnt + 1'b1;
                rd_cnt   <= '0;
                good_cnt <= '0;
            end
            else if (rd_q && rd_data && good_cnt == POS_W'(PREAMBLE_BITS + PAGE_BITS - 1))
            begin
                rd_cnt   <= '0;  // page complete, rewind for the next one
                good_cnt <= '0;
            end
            else
            begin
                if (rd)
                    rd_cnt <= rd_cnt + 1'b1;
                if (rd_q && rd_data)
                    good_cnt <= good_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/position_page_converter.sv
`timescale 1ns/1ps
`default_nettype none

module position_page_converter import bubble_loader_pkg::*;
(
    input  wire              MCLK,
    input  wire              rst_n,
    input  wire              conv,
    input  wire  [POS_W-1:0] abs_pos,
    output logic [POS_W-1:0] page,
    output logic             page_valid
);

    logic [POS_W+1:0] prod;   // (pos + 1) * 3 needs two extra bits
    logic [POS_W+1:0] dvd;
    logic [POS_W-1:0] rem;
    logic [POS_W:0]   trial;
    logic [POS_W:0]   diff;
    logic [3:0]       cnt;
    logic             run;

    // position counts ahead by one, the access type changes before the page does
    assign prod  = ({2'b00, abs_pos} + (POS_W+2)'(1)) * (POS_W+2)'(PAGE_STRIDE);
    assign trial = {rem, dvd[POS_W+1]};
    assign diff  = trial - (POS_W+1)'(PAGE_COUNT);
    assign page  = rem;

    always_ff @(posedge MCLK)
    begin
        if (conv)
        begin
            rem <= {{(POS_W-1){1'b0}}, prod[POS_W+1]};  // top bit alone stays below divisor
            dvd <= {prod[POS_W:0], 1'b0};
        end
        else if (run)
        begin
            rem <= (trial >= (POS_W+1)'(PAGE_COUNT)) ? diff[POS_W-1:0] : trial[POS_W-1:0];
            dvd <= {dvd[POS_W:0], 1'b0};
        end
    end

    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt        <= '0;
            run        <= 1'b0;
            page_valid <= 1'b0;
        end
        else
        begin
            page_valid <= 1'b0;
            if (conv)
            begin
                cnt <= 4'd13;  // 13 steps left after the load
                run <= 1'b1;
            end
            else if (run)
            begin
                cnt <= cnt - 4'd1;
                if (cnt == 4'd1)
                begin
                    run        <= 1'b0;
                    page_valid <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/loader_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module loader_sequencer import bubble_loader_pkg::*;
(
    input  wire               MCLK,
    input  wire               rst_n,
    input  wire  [2:0]        img_num,
    input  wire  [1:0]        acc_type,
    flash_rd_if.seq           flash,
    output logic              conv,
    input  wire  [POS_W-1:0]  page,
    input  wire               page_valid,
    output logic              map_wr,
    output logic              map_wr_data,
    output logic              map_rd,
    input  wire               map_rd_data,
    output logic              buf_wclken_n,
    output logic [BUF_AW-1:0] buf_waddr,
    output logic              buf_wdata
);

    typedef enum logic [2:0] {
        ST_IDLE, ST_ARM, ST_CONV, ST_HDR, ST_BOOT, ST_MAP, ST_PRE, ST_PAGE
    } state_t;

    typedef enum logic [2:0] {
        STP_REQ, STP_RD, STP_LOOK, STP_WAIT, STP_WR
    } step_t;

    state_t           state;
    step_t            step;
    logic             page_ld;  // load in progress is a page access
    logic             good;     // current buffer bit counts toward the target
    logic [POS_W-1:0] bit_cnt;
    logic [POS_W-1:0] tgt;

    always_comb
    begin
        case (state)
            ST_BOOT: tgt = POS_W'(BOOT_BITS);
            ST_MAP:  tgt = POS_W'(MAP_BITS);
            ST_PRE:  tgt = POS_W'(PREAMBLE_BITS);
            default: tgt = POS_W'(PAGE_BITS);
        endcase
    end

    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state            <= ST_IDLE;
            step             <= STP_REQ;
            page_ld          <= 1'b0;
            good             <= 1'b0;
            bit_cnt          <= '0;
            conv             <= 1'b0;
            map_wr           <= 1'b0;
            map_wr_data      <= 1'b0;
            map_rd           <= 1'b0;
            buf_wclken_n     <= 1'b1;
            buf_waddr        <= '0;
            buf_wdata        <= 1'b0;
            flash.start      <= 1'b0;
            flash.addr       <= '0;
            flash.bit_req    <= 1'b0;
            flash.release_cs <= 1'b0;
        end
        else
        begin
            flash.start      <= 1'b0;
            flash.bit_req    <= 1'b0;
            flash.release_cs <= 1'b0;
            conv             <= 1'b0;
            map_wr           <= 1'b0;
            map_rd           <= 1'b0;
            buf_wclken_n     <= 1'b1;
            case (state)
                ST_IDLE:
                    if (!acc_type[1])
                        state <= ST_ARM;
                ST_ARM:
                    if (acc_type[1])
                    begin
                        page_ld <= acc_type[0];
                        bit_cnt <= '0;
                        step    <= STP_REQ;
                        if (acc_type[0])
                        begin
                            conv      <= 1'b1;  // page slot comes from the converter
                            buf_waddr <= BUF_AW'(PAGE_BUF_BASE);
                            state     <= ST_CONV;
                        end
                        else
                        begin
                            flash.addr  <= {2'b00, img_num, POS_W'(BOOT_SLOT), 7'd0};
                            flash.start <= 1'b1;
                            buf_waddr   <= BUF_AW'(BOOT_BUF_BASE);
                            state       <= ST_HDR;
                        end
                    end
                ST_CONV:
                    if (page_valid)
                    begin
                        flash.addr  <= {2'b00, img_num, page, 7'd0};
                        flash.start <= 1'b1;
                        state       <= ST_HDR;
                    end
                ST_HDR:
                    if (!flash.busy && !flash.start)  // busy rises a cycle after start
                        state <= page_ld ? ST_PRE : ST_BOOT;
                default:
                    case (step)
                        STP_REQ:
                            if (bit_cnt == tgt)
                            begin
                                bit_cnt <= '0;
                                if (state == ST_BOOT)
                                    state <= ST_MAP;
                                else if (state == ST_PRE)
                                    state <= ST_PAGE;
                                else
                                begin
                                    flash.release_cs <= 1'b1;  // end of load
                                    state            <= ST_IDLE;
                                end
                            end
                            else if (page_ld)
                            begin
                                map_rd <= 1'b1;
                                step   <= STP_RD;
                            end
                            else
                            begin
                                flash.bit_req <= 1'b1;
                                good          <= 1'b1;
                                step          <= STP_WAIT;
                            end
                        STP_RD:
                            step <= STP_LOOK;  // map data lands next cycle
                        STP_LOOK:
                        begin
                            good <= map_rd_data;
                            if (!map_rd_data || state == ST_PRE)
                            begin
                                buf_wdata    <= map_rd_data;  // zero at bad loops
                                buf_wclken_n <= 1'b0;
                                step         <= STP_WR;
                            end
                            else
                            begin
                                flash.bit_req <= 1'b1;
                                step          <= STP_WAIT;
                            end
                        end
                        STP_WAIT:
                            if (flash.bit_valid)
                            begin
                                buf_wdata    <= flash.bit_data;
                                buf_wclken_n <= 1'b0;
                                map_wr       <= (state == ST_MAP);
                                map_wr_data  <= flash.bit_data;
                                step         <= STP_WR;
                            end
                        default:
                        begin
                            buf_waddr <= buf_waddr + 1'b1;
                            if (good)
                                bit_cnt <= bit_cnt + 1'b1;
                            step <= STP_REQ;
                        end
                    endcase
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/bubble_loader_top.sv
`timescale 1ns/1ps
`default_nettype none

module bubble_loader_top import bubble_loader_pkg::*;
(
    input  wire              MCLK,
    input  wire              rst_n,
    input  wire [2:0]        img_num,
    input  wire [2:0]        acc_type,
    input  wire [POS_W-1:0]  abs_pos,
    input  wire              flash_miso,
    output wire              buf_wclken_n,
    output wire [BUF_AW-1:0] buf_waddr,
    output wire              buf_wdata,
    output wire              flash_cs_n,
    output wire              flash_sck,
    output wire              flash_mosi
);

    wire             conv;
    wire [POS_W-1:0] page;
    wire             page_valid;
    wire             map_wr;
    wire             map_wr_data;
    wire             map_rd;
    wire             map_rd_data;

    flash_rd_if flash_bus ();

    spi_flash_reader reader_i (
        .MCLK  (MCLK),
        .rst_n (rst_n),
        .flash (flash_bus.reader),
        .cs_n  (flash_cs_n),
        .sck   (flash_sck),
        .mosi  (flash_mosi),
        .miso  (flash_miso)
    );

    bad_loop_map map_i (
        .MCLK    (MCLK),
        .rst_n   (rst_n),
        .wr      (map_wr),
        .wr_data (map_wr_data),
        .rd      (map_rd),
        .rd_data (map_rd_data)
    );

    position_page_converter conv_i (
        .MCLK       (MCLK),
        .rst_n      (rst_n),
        .conv       (conv),
        .abs_pos    (abs_pos),
        .page       (page),
        .page_valid (page_valid)
    );

    loader_sequencer seq_i (
        .MCLK         (MCLK),
        .rst_n        (rst_n),
        .img_num      (img_num),
        .acc_type     (acc_type[1:0]),  // start strobe and boot/page select
        .flash        (flash_bus.seq),
        .conv         (conv),
        .page         (page),
        .page_valid   (page_valid),
        .map_wr       (map_wr),
        .map_wr_data  (map_wr_data),
        .map_rd       (map_rd),
        .map_rd_data  (map_rd_data),
        .buf_wclken_n (buf_wclken_n),
        .buf_waddr    (buf_waddr),
        .buf_wdata    (buf_wdata)
    );

endmodule

`default_nettype wire

// File: sim/spi_flash_model.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash_model import bubble_loader_pkg::*;
(
    input  wire                 cs_n,
    input  wire                 sck,
    input  wire                 mosi,
    output logic                miso,
    output int                  proto_errs,
    output logic [FLASH_AW-1:0] last_addr,
    output int                  frames
);

    logic [31:0] hdr = '0;
    int          hdr_bits = 0;
    int          data_cnt = 0;
    logic        in_frame = 1'b0;

    // flash content, about one zero bit in sixteen
    function automatic logic data_bit(input logic [FLASH_AW-1:0] byte_addr,
                                      input logic [2:0] idx);
        logic [31:0] h;
        h = {5'd0, byte_addr, idx} * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        h = h * 32'h85eb_ca6b;
        h = h ^ (h >> 13);
        return h[27:24] != 4'h0;
    endfunction

    initial
    begin
        miso       = 1'b0;
        proto_errs = 0;
        last_addr  = '0;
        frames     = 0;
    end

    always @(negedge cs_n)
    begin
        in_frame = 1'b1;
        hdr_bits = 0;
        data_cnt = 0;
    end

    always @(posedge sck)
    begin
        if (!cs_n && hdr_bits < 32)
        begin
            hdr = {hdr[30:0], mosi};  // command and address arrive MSB first
            hdr_bits++;
            if (hdr_bits == 32)
            begin
                assert (hdr[31:24] == FLASH_READ_CMD)
                else
                begin
                    proto_errs++;
                    $display("flash model received command 0x%02h instead of a read",
                             hdr[31:24]);
                end
                last_addr = hdr[23:0];
                frames++;
            end
        end
    end

    always @(negedge sck)
    begin
        if (!cs_n && hdr_bits == 32)
        begin
            miso = data_bit(last_addr + FLASH_AW'(data_cnt >> 3), 3'(data_cnt & 7));
            data_cnt++;
        end
    end

    always @(posedge cs_n)
    begin
        if (in_frame)
        begin
            assert (hdr_bits == 32)
            else
            begin
                proto_errs++;
                $display("flash model saw chip select rise after only %0d header bits",
                         hdr_bits);
            end
            in_frame = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_bubble_loader.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bubble_loader import bubble_loader_pkg::*; ();

    localparam logic [2:0] IMG = 3'd5;
    // about 8 cycles per bit for the boot load and 10 per page bit, plus margin
    localparam int TIMEOUT_CYCLES = 8 * (BOOT_BITS + MAP_BITS) + 4 * 10 * PAGE_BITS + 20_000;

    logic                MCLK;
    logic                rst_n;
    logic [2:0]          img_num;
    logic [2:0]          acc_type;
    logic [POS_W-1:0]    abs_pos;
    wire                 flash_miso;
    wire                 buf_wclken_n;
    wire  [BUF_AW-1:0]   buf_waddr;
    wire                 buf_wdata;
    wire                 flash_cs_n;
    wire                 flash_sck;
    wire                 flash_mosi;
    int                  proto_errs;
    logic [FLASH_AW-1:0] frame_addr;
    int                  frames;

    integer           seed = 32'he851_38ce;
    int               mismatch_errs = 0;
    int               other_errs = 0;
    int               cycles = 0;
    int               wr_idx = 0;
    int               exp_len = 0;
    logic             load_active = 1'b0;
    logic             cur_page_ld = 1'b0;
    logic [POS_W-1:0] cur_slot = '0;
    string            cur_test = "idle";

    bubble_loader_top dut_i (
        .MCLK         (MCLK),
        .rst_n        (rst_n),
        .img_num      (img_num),
        .acc_type     (acc_type),
        .abs_pos      (abs_pos),
        .flash_miso   (flash_miso),
        .buf_wclken_n (buf_wclken_n),
        .buf_waddr    (buf_waddr),
        .buf_wdata    (buf_wdata),
        .flash_cs_n   (flash_cs_n),
        .flash_sck    (flash_sck),
        .flash_mosi   (flash_mosi)
    );

    spi_flash_model flash_i (
        .cs_n       (flash_cs_n),
        .sck        (flash_sck),
        .mosi       (flash_mosi),
        .miso       (flash_miso),
        .proto_errs (proto_errs),
        .last_addr  (frame_addr),
        .frames     (frames)
    );

    function automatic logic flash_bit(input logic [FLASH_AW-1:0] byte_addr,
                                       input logic [2:0] idx);
        logic [31:0] h;
        h = {5'd0, byte_addr, idx} * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        h = h * 32'h85eb_ca6b;
        h = h ^ (h >> 13);
        return h[27:24] != 4'h0;
    endfunction

    // n-th bit of the read stream starting at a slot of the test image
    function automatic logic stream_bit(input logic [POS_W-1:0] slot, input int n);
        logic [FLASH_AW-1:0] start;
        start = {2'b00, IMG, slot, 7'd0};
        return flash_bit(start + FLASH_AW'(n >> 3), 3'(n & 7));
    endfunction

    // table entry k as read back, written with its low nibble inverted
    function automatic logic map_entry(input int k);
        logic [POS_W-1:0] j;
        j      = POS_W'(k);
        j[3:0] = ~j[3:0];
        return stream_bit(POS_W'(BOOT_SLOT), BOOT_BITS + int'(j));
    endfunction

    function automatic int map_good_count();
        int good;
        good = 0;
        for (int k = 0; k < MAP_BITS; k++)
        begin
            if (map_entry(k))
                good++;
        end
        return good;
    endfunction

    // buffer writes of one page load, bad loops included
    function automatic int page_write_count();
        int k;
        int good;
        k    = 0;
        good = 0;
        while (good < PREAMBLE_BITS + PAGE_BITS && k < MAP_BITS)
        begin
            if (map_entry(k))
                good++;
            k++;
        end
        return k;
    endfunction

    function automatic int page_of(input logic [POS_W-1:0] pos);
        return ((int'(pos) + 1) * PAGE_STRIDE) % PAGE_COUNT;
    endfunction

    function automatic logic expected_bit(input logic page_ld, input logic [POS_W-1:0] slot,
                                          input int n);
        int   good;
        int   s;
        logic m;
        good = 0;
        s    = 0;
        if (!page_ld)
            return stream_bit(POS_W'(BOOT_SLOT), n);  // boot bits, then map bits
        for (int k = 0; k < n; k++)
        begin
            if (map_entry(k))
            begin
                if (good >= PREAMBLE_BITS)
                    s++;  // only page data takes flash bits
                good++;
            end
        end
        m = map_entry(n);
        if (good < PREAMBLE_BITS)
            return m;  // preamble one, zero at a bad loop
        return m ? stream_bit(slot, s) : 1'b0;
    endfunction

    task automatic print_counts();
        $display("errors: %0d mismatch, %0d other, %0d flash protocol",
                 mismatch_errs, other_errs, proto_errs);
    endtask

    task automatic run_load(input logic page_ld, input logic [POS_W-1:0] pos,
                            input string name);
        logic [POS_W-1:0] slot;
        int               frames_before;
        slot          = page_ld ? POS_W'(page_of(pos)) : POS_W'(BOOT_SLOT);
        cur_page_ld   = page_ld;
        cur_slot      = slot;
        cur_test      = name;
        wr_idx        = 0;
        exp_len       = page_ld ? page_write_count() : BOOT_BITS + MAP_BITS;
        frames_before = frames;
        load_active   = 1'b1;
        acc_type <= {2'b00, page_ld};  // arm
        abs_pos  <= pos;
        repeat (2) @(posedge MCLK);
        acc_type <= {2'b01, page_ld};
        while (flash_cs_n)
            @(posedge MCLK);
        while (!flash_cs_n)
            @(posedge MCLK);  // cs_n rising marks the end of the load
        load_active = 1'b0;
        assert (wr_idx == exp_len)
        else
        begin
            mismatch_errs++;
            $display("mismatch %s write count: expected %0d actual %0d", name, exp_len, wr_idx);
        end
        assert (frames == frames_before + 1)
        else
        begin
            other_errs++;
            $display("%s opened %0d flash read frames instead of one", name,
                     frames - frames_before);
        end
        assert (frame_addr == {2'b00, IMG, slot, 7'd0})
        else
        begin
            mismatch_errs++;
            $display("mismatch %s flash address: expected %06h actual %06h", name,
                     {2'b00, IMG, slot, 7'd0}, frame_addr);
        end
        repeat (4) @(posedge MCLK);
    endtask

    initial
    begin
        MCLK = 1'b0;
        forever #4 MCLK = ~MCLK;
    end

    always @(posedge MCLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            other_errs++;
            $display("timeout: %s still running after %0d cycles", cur_test, cycles);
            print_counts();
            $display("TEST FAIL");
            $finish;
        end
    end

    // buffer write checker
    always @(posedge MCLK)
    begin
        int   exp_addr;
        logic exp_data;
        if (rst_n && !buf_wclken_n)
        begin
            assert (load_active && wr_idx < exp_len)
            else
            begin
                other_errs++;
                $display("unexpected buffer write at address %0d during %s", buf_waddr, cur_test);
            end
            if (load_active && wr_idx < exp_len)
            begin
                exp_addr = (cur_page_ld ? PAGE_BUF_BASE : BOOT_BUF_BASE) + wr_idx;
                exp_data = expected_bit(cur_page_ld, cur_slot, wr_idx);
                assert (buf_waddr === BUF_AW'(exp_addr))
                else
                begin
                    mismatch_errs++;
                    $display("mismatch %s address at write %0d: expected %0d actual %0d",
                             cur_test, wr_idx, exp_addr, buf_waddr);
                end
                assert (buf_wdata === exp_data)
                else
                begin
                    mismatch_errs++;
                    $display("mismatch %s data at write %0d: expected %0b actual %0b",
                             cur_test, wr_idx, exp_data, buf_wdata);
                end
            end
            if (load_active)
                wr_idx++;
        end
    end

    initial
    begin
        logic [POS_W-1:0] pos;
        int               good;
        rst_n    = 1'b0;
        img_num  = IMG;
        acc_type = 3'b010;  // bit 1 high keeps the sequencer idle
        abs_pos  = '0;
        repeat (8) @(posedge MCLK);
        rst_n <= 1'b1;
        @(posedge MCLK);
        assert (buf_wclken_n === 1'b1 && flash_cs_n === 1'b1 && flash_sck === 1'b1)
        else
        begin
            other_errs++;
            $display("buffer strobe, chip select or SCK is not high after reset");
        end
        repeat (20) @(posedge MCLK);  // idle, any write is flagged
        run_load(1'b0, '0, "boot load");
        good = map_good_count();
        assert (good >= PREAMBLE_BITS + PAGE_BITS)
        else
        begin
            other_errs++;
            $display("flash image holds only %0d good loops, a page needs %0d", good,
                     PREAMBLE_BITS + PAGE_BITS);
        end
        for (int i = 0; i < 3; i++)
        begin
            pos = POS_W'($random(seed));
            run_load(1'b1, pos, $sformatf("page load pos %0d", pos));
        end
        run_load(1'b1, POS_W'(4095), "page load pos 4095");  // page number wraps
        print_counts();
        if (mismatch_errs + other_errs + proto_errs == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
rtl/bubble_loader_pkg.sv
rtl/flash_rd_if.sv
rtl/spi_flash_reader.sv
rtl/bad_loop_map.sv
rtl/position_page_converter.sv
rtl/loader_sequencer.sv
rtl/bubble_loader_top.sv
sim/spi_flash_model.sv
sim/tb_bubble_loader.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_bubble_loader -o tb_bubble_loader

./obj_dir/tb_bubble_loader | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi
